// File: rtl/bounce_pkg.sv
// bounce display shared definitions
// square state, host config word, sequencer states and reset speeds
`default_nettype none

package bounce_pkg;

    localparam int coord_w = 10;      // screen coordinate width
    localparam int num_squares = 3;

    typedef logic [coord_w-1:0] coord_t;

    // position is the top-left corner
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   dx;                   // 1 moves left
        logic   dy;                   // 1 moves up
    } square_t;

    typedef struct packed {
        logic [1:0] sel;              // square index 0..2
        coord_t     speed;
    } cfg_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_STEP,
        SEQ_ACK,
        SEQ_RELEASE
    } seq_state_t;

    localparam coord_t reset_speed [num_squares] = '{
        coord_t'(2),
        coord_t'(1),
        coord_t'(1)
    };

endpackage

`default_nettype wire

// File: rtl/display_timings.sv
// display timings
// pixel and line counters over the full blanked frame, active-low syncs and data enable
`timescale 1ns/1ps
`default_nettype none

module display_timings #(
    parameter int h_res  = 640,
    parameter int h_fp   = 16,
    parameter int h_sync = 96,
    parameter int h_bp   = 48,
    parameter int v_res  = 480,
    parameter int v_fp   = 10,
    parameter int v_sync = 2,
    parameter int v_bp   = 33
) (
    input  wire logic         clk_pix,
    input  wire logic         reset,
    output bounce_pkg::coord_t sx,
    output bounce_pkg::coord_t sy,
    output logic              hsync,
    output logic              vsync,
    output logic              de
);
    import bounce_pkg::*;

    localparam coord_t h_sync_start = coord_t'(h_res + h_fp);
    localparam coord_t h_sync_end   = coord_t'(h_res + h_fp + h_sync);
    localparam coord_t h_last       = coord_t'(h_res + h_fp + h_sync + h_bp - 1);
    localparam coord_t v_sync_start = coord_t'(v_res + v_fp);
    localparam coord_t v_sync_end   = coord_t'(v_res + v_fp + v_sync);
    localparam coord_t v_last       = coord_t'(v_res + v_fp + v_sync + v_bp - 1);

    always_comb begin
        hsync = ~((sx >= h_sync_start) && (sx < h_sync_end));  // active low
        vsync = ~((sy >= v_sync_start) && (sy < v_sync_end));
        de    = (sx < coord_t'(h_res)) && (sy < coord_t'(v_res));
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == h_last) begin   // end of line
            sx <= '0;
            sy <= (sy == v_last) ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/frame_sequencer.sv
// frame sequencer
// steps the squares once per frame and serves the host speed handshake
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer #(
    parameter int v_res = 480
) (
    input  wire logic                               clk_pix,
    input  wire logic                               reset,
    input  wire bounce_pkg::coord_t                 sx,
    input  wire bounce_pkg::coord_t                 sy,
    input  wire logic                               cfg_req,
    input  wire bounce_pkg::cfg_t                   cfg,
    output logic                                    cfg_ack,
    output logic [bounce_pkg::num_squares-1:0]      step,
    output logic                                    load,
    output bounce_pkg::coord_t                      load_speed,
    output logic [1:0]                              load_sel
);
    import bounce_pkg::*;

    seq_state_t state;
    logic [1:0] step_idx;
    logic       frame_start;   // first blanking line, column 0
    logic       frame_pend;    // frame start seen while busy
    logic       go_step;
    logic       accept;

    always_comb begin
        frame_start = (sy == coord_t'(v_res)) && (sx == '0);
        go_step     = frame_start || frame_pend;
        accept      = (state == SEQ_IDLE) && !go_step && cfg_req;
        step        = '0;
        if (state == SEQ_STEP) begin
            step[step_idx] = 1'b1;          // one square per cycle
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state      <= SEQ_IDLE;
            step_idx   <= '0;
            frame_pend <= 1'b0;
            cfg_ack    <= 1'b0;
            load       <= 1'b0;
        end else begin
            load <= accept;
            if (frame_start && state != SEQ_IDLE) begin
                frame_pend <= 1'b1;
            end
            case (state)
                SEQ_IDLE: begin
                    if (go_step) begin
                        state      <= SEQ_STEP;
                        frame_pend <= 1'b0;
                    end else if (cfg_req) begin
                        state   <= SEQ_ACK;
                        cfg_ack <= 1'b1;
                    end
                end
                SEQ_STEP: begin
                    if (step_idx == 2'(num_squares - 1)) begin
                        state    <= SEQ_IDLE;
                        step_idx <= '0;
                    end else begin
                        step_idx <= step_idx + 1'b1;
                    end
                end
                SEQ_ACK: begin
                    if (!cfg_req) begin       // host released
                        state   <= SEQ_RELEASE;
                        cfg_ack <= 1'b0;
                    end
                end
                SEQ_RELEASE: state <= SEQ_IDLE;
                default:     state <= SEQ_IDLE;
            endcase
        end
    end

    // request payload, captured once per accepted request
    always_ff @(posedge clk_pix) begin
        if (accept) begin
            load_speed <= cfg.speed;
            load_sel   <= cfg.sel;
        end
    end

endmodule

`default_nettype wire

// File: rtl/square_mover.sv
// square mover
// one square's position, direction and speed, bounced off the screen edges on step
`timescale 1ns/1ps
`default_nettype none

module square_mover #(
    parameter int index = 0,
    parameter int size  = 100,
    parameter int h_res = 640,
    parameter int v_res = 480
) (
    input  wire logic               clk_pix,
    input  wire logic               reset,
    input  wire logic               step,
    input  wire logic               load,
    input  wire logic [1:0]         load_sel,
    input  wire bounce_pkg::coord_t load_speed,
    output bounce_pkg::square_t     sq
);
    import bounce_pkg::*;

    coord_t speed;
    coord_t x_next;
    coord_t y_next;
    logic   dx_next;
    logic   dy_next;

    // bounce rule for one axis
    function automatic void bounce_axis(
        input  coord_t pos,
        input  logic   dir,
        input  coord_t spd,
        input  int     limit,
        output coord_t pos_n,
        output logic   dir_n
    );
        int far_edge;
        far_edge = limit - (size + int'(spd));
        dir_n    = dir;
        if (int'(pos) >= far_edge) begin      // right or bottom edge
            dir_n = 1'b1;
            pos_n = pos - spd;
        end else if (pos < spd) begin         // left or top edge
            dir_n = 1'b0;
            pos_n = pos + spd;
        end else begin
            pos_n = dir ? pos - spd : pos + spd;
        end
    endfunction

    always_comb begin
        bounce_axis(sq.x, sq.dx, speed, h_res, x_next, dx_next);
        bounce_axis(sq.y, sq.dy, speed, v_res, y_next, dy_next);
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sq    <= '0;
            speed <= reset_speed[index];
        end else begin
            if (load && load_sel == 2'(index)) begin
                speed <= load_speed;
            end
            if (step) begin
                sq.x  <= x_next;
                sq.y  <= y_next;
                sq.dx <= dx_next;
                sq.dy <= dy_next;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/pixel_painter.sv
// pixel painter
// hit test for the three squares, registered colour and sync outputs
`timescale 1ns/1ps
`default_nettype none

module pixel_painter #(
    parameter int q1_size = 100,
    parameter int q2_size = 150,
    parameter int q3_size = 200
) (
    input  wire logic                clk_pix,
    input  wire logic                reset,
    input  wire bounce_pkg::coord_t  sx,
    input  wire bounce_pkg::coord_t  sy,
    input  wire logic                hsync,
    input  wire logic                vsync,
    input  wire logic                de,
    input  wire bounce_pkg::square_t sq0,
    input  wire bounce_pkg::square_t sq1,
    input  wire bounce_pkg::square_t sq2,
    output logic                     vga_hsync,
    output logic                     vga_vsync,
    output logic [3:0]               vga_r,
    output logic [3:0]               vga_g,
    output logic [3:0]               vga_b
);
    import bounce_pkg::*;

    logic q1_draw;
    logic q2_draw;
    logic q3_draw;

    // start inclusive, end exclusive
    function automatic logic hit_square(
        input coord_t  px,
        input coord_t  py,
        input square_t sq,
        input int      size
    );
        return (px >= sq.x) && (int'(px) < int'(sq.x) + size)
            && (py >= sq.y) && (int'(py) < int'(sq.y) + size);
    endfunction

    always_comb begin
        q1_draw = hit_square(sx, sy, sq0, q1_size);
        q2_draw = hit_square(sx, sy, sq1, q2_size);
        q3_draw = hit_square(sx, sy, sq2, q3_size);
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            vga_hsync <= 1'b1;      // syncs idle high
            vga_vsync <= 1'b1;
            vga_r     <= 4'h0;
            vga_g     <= 4'h0;
            vga_b     <= 4'h0;
        end else begin
            vga_hsync <= hsync;
            vga_vsync <= vsync;
            vga_r     <= (de && q1_draw) ? 4'hf : 4'h0;
            vga_g     <= (de && q2_draw) ? 4'hf : 4'h0;
            vga_b     <= (de && q3_draw) ? 4'hf : 4'h0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/bounce_display.sv
// bounce display top
// timing counter, frame sequencer, three square movers and the VGA painter
`timescale 1ns/1ps
`default_nettype none

module bounce_display #(
    parameter int h_res   = 640,
    parameter int h_fp    = 16,
    parameter int h_sync  = 96,
    parameter int h_bp    = 48,
    parameter int v_res   = 480,
    parameter int v_fp    = 10,
    parameter int v_sync  = 2,
    parameter int v_bp    = 33,
    parameter int q1_size = 100,
    parameter int q2_size = 150,
    parameter int q3_size = 200
) (
    input  wire logic             clk_pix,
    input  wire logic             reset,
    input  wire logic             cfg_req,
    input  wire bounce_pkg::cfg_t cfg,
    output logic                  cfg_ack,
    output logic                  vga_hsync,
    output logic                  vga_vsync,
    output logic [3:0]            vga_r,
    output logic [3:0]            vga_g,
    output logic [3:0]            vga_b
);
    import bounce_pkg::*;

    localparam int sq_size [num_squares] = '{q1_size, q2_size, q3_size};

    coord_t                 sx;
    coord_t                 sy;
    logic                   hsync;
    logic                   vsync;
    logic                   de;
    logic [num_squares-1:0] step;       // one strobe per square
    logic                   load;
    coord_t                 load_speed;
    logic [1:0]             load_sel;
    square_t                sq [num_squares];

    display_timings #(
        .h_res(h_res), .h_fp(h_fp), .h_sync(h_sync), .h_bp(h_bp),
        .v_res(v_res), .v_fp(v_fp), .v_sync(v_sync), .v_bp(v_bp)
    ) timings_i (
        .clk_pix(clk_pix),
        .reset(reset),
        .sx(sx),
        .sy(sy),
        .hsync(hsync),
        .vsync(vsync),
        .de(de)
    );

    frame_sequencer #(
        .v_res(v_res)
    ) sequencer_i (
        .clk_pix(clk_pix),
        .reset(reset),
        .sx(sx),
        .sy(sy),
        .cfg_req(cfg_req),
        .cfg(cfg),
        .cfg_ack(cfg_ack),
        .step(step),
        .load(load),
        .load_speed(load_speed),
        .load_sel(load_sel)
    );

    for (genvar i = 0; i < num_squares; i++) begin : g_mover
        square_mover #(
            .index(i), .size(sq_size[i]), .h_res(h_res), .v_res(v_res)
        ) mover_i (
            .clk_pix(clk_pix),
            .reset(reset),
            .step(step[i]),
            .load(load),
            .load_sel(load_sel),
            .load_speed(load_speed),
            .sq(sq[i])
        );
    end

    pixel_painter #(
        .q1_size(q1_size), .q2_size(q2_size), .q3_size(q3_size)
    ) painter_i (
        .clk_pix(clk_pix),
        .reset(reset),
        .sx(sx),
        .sy(sy),
        .hsync(hsync),
        .vsync(vsync),
        .de(de),
        .sq0(sq[0]),
        .sq1(sq[1]),
        .sq2(sq[2]),
        .vga_hsync(vga_hsync),
        .vga_vsync(vga_vsync),
        .vga_r(vga_r),
        .vga_g(vga_g),
        .vga_b(vga_b)
    );

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
// testbench clock and reset source
// free-running pixel clock, reset held high for a fixed number of cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int half_period  = 10,  // 20 ns period
    parameter int reset_cycles = 16
) (
    output logic clk_pix,
    output logic reset
);

    initial begin
        clk_pix = 1'b0;
        forever #(half_period) clk_pix = ~clk_pix;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk_pix);
        #1 reset = 1'b0;                  // released just after the edge
    end

endmodule

`default_nettype wire

// File: verif/bounce_display_properties.sv
// bounce display properties
// config handshake ordering, single step strobe and hsync pulse width
`timescale 1ns/1ps
`default_nettype none

module bounce_display_properties #(
    parameter int h_sync = 96
) (
    input wire logic       clk_pix,
    input wire logic       reset,
    input wire logic       cfg_req,
    input wire logic       cfg_ack,
    input wire logic [2:0] step,
    input wire logic       vga_hsync
);

    int low_run;                          // length of current hsync pulse
    int fail_count = 0;                   // failed assertions so far

    always_ff @(posedge clk_pix) begin
        if (reset || vga_hsync) begin
            low_run <= 0;
        end else begin
            low_run <= low_run + 1;
        end
    end

    ack_rise_a: assert property (@(posedge clk_pix) disable iff (reset)
        $rose(cfg_ack) |-> $past(cfg_req))
        else begin
            fail_count++;
            $error("cfg_ack rose while cfg_req was low");
        end

    ack_fall_a: assert property (@(posedge clk_pix) disable iff (reset)
        $fell(cfg_ack) |-> !$past(cfg_req))
        else begin
            fail_count++;
            $error("cfg_ack fell before cfg_req was seen low");
        end

    // each burst is one strobe per cycle, square 0 first
    step_one_a: assert property (@(posedge clk_pix) disable iff (reset)
        $rose(|step) |-> (step == 3'b001) ##1 (step == 3'b010) ##1 (step == 3'b100)
            ##1 (step == 3'b000))
        else begin
            fail_count++;
            $error("step strobes not one per cycle in square order");
        end

    hsync_width_a: assert property (@(posedge clk_pix) disable iff (reset)
        $rose(vga_hsync) |-> low_run == h_sync)
        else begin
            fail_count++;
            $error("hsync pulse width differs from h_sync");
        end

endmodule

bind bounce_display bounce_display_properties #(
    .h_sync(h_sync)
) props_i (
    .clk_pix(clk_pix),
    .reset(reset),
    .cfg_req(cfg_req),
    .cfg_ack(cfg_ack),
    .step(step),
    .vga_hsync(vga_hsync)
);

`default_nettype wire

// File: verif/bounce_display_tb.sv
// bounce display testbench
// tiny screen, speed requests from a table, every output pixel checked against a model
`timescale 1ns/1ps
`default_nettype none

module bounce_display_tb;
    import bounce_pkg::*;

    localparam int h_res   = 32;
    localparam int h_fp    = 2;
    localparam int h_sync  = 4;
    localparam int h_bp    = 2;
    localparam int v_res   = 24;
    localparam int v_fp    = 1;
    localparam int v_sync  = 2;
    localparam int v_bp    = 1;
    localparam int q1_size = 4;
    localparam int q2_size = 6;
    localparam int q3_size = 8;
    localparam int h_total = h_res + h_fp + h_sync + h_bp;
    localparam int v_total = v_res + v_fp + v_sync + v_bp;
    localparam int frame_cycles = h_total * v_total;
    localparam int ack_timeout  = 200;
    localparam int num_rows     = 5;

    typedef struct {
        int    frame;
        int    sel;
        int    speed;
        string name;
    } req_row_t;

    logic       clk_pix;
    logic       reset;
    logic       cfg_req;
    cfg_t       cfg;
    logic       cfg_ack;
    logic       vga_hsync;
    logic       vga_vsync;
    logic [3:0] vga_r;
    logic [3:0] vga_g;
    logic [3:0] vga_b;

    req_row_t rows [num_rows];
    int       sizes [3] = '{q1_size, q2_size, q3_size};
    int       pos_x [3];                  // model square state
    int       pos_y [3];
    int       dir_x [3];
    int       dir_y [3];
    int       speed [3];
    int       cur_sx;                     // own copy of the counters
    int       cur_sy;
    int       frame_no = 0;
    int       errors = 0;
    int       checks = 0;
    bit       done = 1'b0;
    string    test_name = "reset";
    event     run_end;

    tb_clock clock_i (.clk_pix(clk_pix), .reset(reset));

    bounce_display #(
        .h_res(h_res), .h_fp(h_fp), .h_sync(h_sync), .h_bp(h_bp),
        .v_res(v_res), .v_fp(v_fp), .v_sync(v_sync), .v_bp(v_bp),
        .q1_size(q1_size), .q2_size(q2_size), .q3_size(q3_size)
    ) dut_i (
        .clk_pix(clk_pix),
        .reset(reset),
        .cfg_req(cfg_req),
        .cfg(cfg),
        .cfg_ack(cfg_ack),
        .vga_hsync(vga_hsync),
        .vga_vsync(vga_vsync),
        .vga_r(vga_r),
        .vga_g(vga_g),
        .vga_b(vga_b)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic timed_out(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
        -> run_end;
    endtask

    function automatic logic [31:0] pins_now();
        return 32'({vga_hsync, vga_vsync, vga_r, vga_g, vga_b});
    endfunction

    // one axis of the bounce rule, span is the limit minus the size
    function automatic int next_pos(input int pos, input int dir, input int spd,
                                    input int span, output int dir_n);
        dir_n = dir;
        if (pos >= span - spd) begin
            dir_n = 1;
            return pos - spd;
        end
        if (pos < spd) begin
            dir_n = 0;
            return pos + spd;
        end
        return (dir == 1) ? pos - spd : pos + spd;
    endfunction

    function automatic void step_model();
        for (int i = 0; i < 3; i++) begin
            pos_x[i] = next_pos(pos_x[i], dir_x[i], speed[i], h_res - sizes[i], dir_x[i]);
            pos_y[i] = next_pos(pos_y[i], dir_y[i], speed[i], v_res - sizes[i], dir_y[i]);
        end
    endfunction

    function automatic logic [13:0] expected_pins(input int px, input int py);
        logic       hs;
        logic       vs;
        logic       active;
        logic [2:0] hit;
        hs     = !(px >= h_res + h_fp && px < h_res + h_fp + h_sync);
        vs     = !(py >= v_res + v_fp && py < v_res + v_fp + v_sync);
        active = (px < h_res) && (py < v_res);
        for (int i = 0; i < 3; i++) begin
            hit[i] = active && px >= pos_x[i] && px < pos_x[i] + sizes[i]
                && py >= pos_y[i] && py < pos_y[i] + sizes[i];
        end
        return {hs, vs, {4{hit[0]}}, {4{hit[1]}}, {4{hit[2]}}};
    endfunction

    task automatic wait_frame(input int target);
        int n;
        int limit;
        limit = (target - frame_no + 1) * frame_cycles;
        for (n = 0; n < limit && frame_no < target; n++) begin
            @(posedge clk_pix);
            #1;
        end
        if (frame_no < target) timed_out($sformatf("frame %0d", target));
    endtask

    // four-phase exchange, host side
    task automatic do_handshake(input int sel, input int spd);
        int n;
        cfg.sel   = 2'(sel);
        cfg.speed = coord_t'(spd);
        cfg_req   = 1'b1;
        for (n = 0; n < ack_timeout && !cfg_ack; n++) begin
            @(posedge clk_pix);
            #1;
        end
        if (!cfg_ack) timed_out("cfg_ack to rise");
        cfg_req = 1'b0;
        for (n = 0; n < ack_timeout && cfg_ack; n++) begin
            @(posedge clk_pix);
            #1;
        end
        if (cfg_ack) timed_out("cfg_ack to fall");
        check_value($sformatf("%s cfg_ack fall cycles", test_name), 32'd1, 32'(n));
    endtask

    // pins of cycle n+1 belong to the counters of cycle n
    initial begin : pixel_checker
        int   n;
        int   prev_sx;
        int   prev_sy;
        logic prev_ack;
        for (n = 0; n < 100; n++) begin
            @(negedge clk_pix);
            if (!reset) break;
            check_value("during reset", 32'h3000, pins_now());
            check_value("cfg_ack during reset", 32'h0, 32'(cfg_ack));
        end
        if (reset) timed_out("reset release");
        cur_sx   = 0;
        cur_sy   = 0;
        prev_ack = 1'b0;
        check_value("reset release", 32'h3000, pins_now());
        for (n = 0; n < 30 * frame_cycles && !done; n++) begin
            prev_sx = cur_sx;
            prev_sy = cur_sy;
            @(negedge clk_pix);
            cur_sx++;
            if (cur_sx == h_total) begin
                cur_sx = 0;
                cur_sy++;
                if (cur_sy == v_total) begin
                    cur_sy = 0;
                    frame_no++;
                end
            end
            check_value($sformatf("%s px %0d,%0d", test_name, prev_sx, prev_sy),
                        32'(expected_pins(prev_sx, prev_sy)), pins_now());
            if (cfg_ack && !prev_ack) speed[cfg.sel] = int'(cfg.speed);  // new speed
            prev_ack = cfg_ack;
            if (cur_sy == v_res && cur_sx == 0) step_model();   // frame start
        end
        if (!done) timed_out("end of stimulus");
    end

    initial begin : stimulus
        int n;
        int gap;
        cfg_req = 1'b0;
        cfg     = '0;
        void'($urandom(32'h8c57a9ad));
        rows[0] = '{1, 1, 3, "sq1 speed 3"};
        rows[1] = '{3, 2, 4, "sq2 speed 4"};
        rows[2] = '{5, 0, 5, "sq0 speed 5"};
        rows[3] = '{7, 1, 2, "sq1 speed 2"};
        rows[4] = '{9, 0, 1, "sq0 speed 1"};
        for (int i = 0; i < 3; i++) begin
            pos_x[i] = 0;
            pos_y[i] = 0;
            dir_x[i] = 0;
            dir_y[i] = 0;
        end
        speed = '{2, 1, 1};               // reset speeds
        for (n = 0; n < 100 && reset !== 1'b0; n++) begin
            @(posedge clk_pix);
            #1;
        end
        if (reset !== 1'b0) timed_out("reset release");
        test_name = "first frame";
        for (int r = 0; r < num_rows; r++) begin
            wait_frame(rows[r].frame);
            test_name = rows[r].name;
            gap = $urandom_range(1000, 0);
            repeat (gap) @(posedge clk_pix);
            #1;
            do_handshake(rows[r].sel, rows[r].speed);
        end
        wait_frame(12);
        test_name = "req at frame start";
        for (n = 0; n < 2 * frame_cycles; n++) begin
            if (cur_sy == v_res - 1 && cur_sx == h_total - 1) break;  // last cycle seen
            @(posedge clk_pix);
            #1;
        end
        if (!(cur_sy == v_res - 1 && cur_sx == h_total - 1)) timed_out("frame start");
        do_handshake(2, 2);
        wait_frame(frame_no + 3);
        done = 1'b1;
        -> run_end;
    end

    initial begin : report
        @(run_end);
        errors += dut_i.props_i.fail_count;   // failed assertions
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bounce_display.f
rtl/bounce_pkg.sv
rtl/display_timings.sv
rtl/frame_sequencer.sv
rtl/square_mover.sv
rtl/pixel_painter.sv
rtl/bounce_display.sv
verif/tb_clock.sv
verif/bounce_display_properties.sv
verif/bounce_display_tb.sv

// File: Makefile
TOOL       = verilator
TOP        = bounce_display_tb
FILELIST   = bounce_display.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = ALL CHECKS PASSED
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0

.PHONY: lint sim build clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
